// ==== common/cp0_config.svh ====
`ifndef CP0_CONFIG_SVH
`define CP0_CONFIG_SVH

`define TLB_LINE_NUM      16        // also sets index and wired width

// register numbers as seen by mtc0/mfc0
`define CP0_REG_INDEX     5'd0
`define CP0_REG_RANDOM    5'd1
`define CP0_REG_ENTRYLO0  5'd2
`define CP0_REG_ENTRYLO1  5'd3
`define CP0_REG_PAGEMASK  5'd5
`define CP0_REG_WIRED     5'd6
`define CP0_REG_BADVADDR  5'd8
`define CP0_REG_COUNT     5'd9
`define CP0_REG_ENTRYHI   5'd10
`define CP0_REG_COMPARE   5'd11
`define CP0_REG_STATUS    5'd12
`define CP0_REG_CAUSE     5'd13
`define CP0_REG_EPC       5'd14
`define CP0_REG_PRID      5'd15     // sel 1 is ebase
`define CP0_REG_CONFIG    5'd16

// reset words
`define CP0_STATUS_RESET  32'h0040_0000   // bev set
`define CP0_CONFIG_RESET  32'h0000_8000
`define CP0_PRID_VALUE    32'h0001_8003
`define CP0_EBASE_RESET   32'h8000_0000

// exception vectors
`define CP0_BOOT_VECTOR   32'hbfc0_0200
`define CP0_GEN_OFFSET    32'h0000_0180

`endif

// ==== common/cp0_pkg.sv ====
package cp0_pkg;

   // cause excode values
   typedef enum logic [4:0] {
      EXC_INT  = 5'd0,
      EXC_MOD  = 5'd1,
      EXC_TLBL = 5'd2,
      EXC_TLBS = 5'd3,
      EXC_ADEL = 5'd4,
      EXC_ADES = 5'd5,
      EXC_SYS  = 5'd8,
      EXC_BP   = 5'd9,
      EXC_RI   = 5'd10,
      EXC_OV   = 5'd12,
      EXC_TR   = 5'd13
   } exc_code_e;

   // fault flags of the memory-stage instruction
   typedef struct packed {
      logic ri;
      logic brk;
      logic syscall;
      logic ovf;
      logic adel;
      logic ades;
      logic pc_err;
      logic trap;
      logic eret;
      logic itlb_refill;
      logic itlb_inv;
      logic dtlb_refill;
      logic dtlb_inv;
      logic dtlb_mod;
      logic mem_read;
      logic mem_write;
   } except_req_t;

   typedef struct packed {
      logic [31:0] pc;
      logic        in_delay_slot;
      logic [31:0] data_addr;     // alu result
   } inst_info_t;

   typedef struct packed {
      logic        we;
      logic [4:0]  addr;
      logic [2:0]  sel;
      logic [31:0] data;
   } cp0_wr_t;

   typedef struct packed {
      logic tlbwr;
      logic tlbwi;
      logic tlbr;
      logic tlbp;
   } tlb_op_t;

   typedef struct packed {
      logic [31:0] entry_hi;
      logic [31:0] entry_lo0;
      logic [31:0] entry_lo1;
      logic [31:0] page_mask;
      logic [31:0] index;
   } tlb_entry_t;

   typedef struct packed {
      logic      valid;
      exc_code_e code;
      logic      is_eret;
      logic      tlb_refill;
      logic      is_tlb;         // mod, tlbl or tlbs
      logic      has_badvaddr;
      logic      bad_from_pc;    // fault address is the pc
   } except_t;

   typedef struct packed {
      logic [3:0] cu;
      logic [4:0] rsv0;
      logic       bev;
      logic [5:0] rsv1;
      logic [7:0] im;
      logic [5:0] rsv2;
      logic       exl;
      logic       ie;
   } status_view_t;

   typedef struct packed {
      logic       bd;
      logic       ti;
      logic [5:0] rsv0;
      logic       iv;
      logic       wp;
      logic [5:0] rsv1;
      logic [5:0] ip_hw;       // ip7..ip2
      logic [1:0] ip_sw;
      logic       rsv2;
      exc_code_e  exc_code;
      logic [1:0] rsv3;
   } cause_view_t;

   typedef struct packed {
      logic [18:0] vpn2;
      logic [4:0]  rsv;
      logic [7:0]  asid;
   } entry_hi_view_t;

   // one mtc0 data word, decoded by target register
   typedef union packed {
      logic [31:0]    word;
      status_view_t   status;
      cause_view_t    cause;
      entry_hi_view_t entry_hi;
   } cp0_word_u;

endpackage

// ==== cp0/cp0_except_arb.sv ====
module cp0_except_arb import cp0_pkg::*; (
   input  except_req_t except_req_i,
   input  logic [31:0] status_i,
   input  logic [31:0] cause_i,
   output except_t     except_o,
   output logic        int_pending_o
);

   cp0_word_u status_w;
   cp0_word_u cause_w;
   logic      itlb_fault;
   logic      dtlb_load;
   logic      dtlb_store;

   assign status_w.word = status_i;
   assign cause_w.word  = cause_i;

   assign itlb_fault = except_req_i.itlb_refill | except_req_i.itlb_inv;
   assign dtlb_load  = except_req_i.mem_read & (except_req_i.dtlb_refill | except_req_i.dtlb_inv);
   assign dtlb_store = except_req_i.mem_write & (except_req_i.dtlb_refill | except_req_i.dtlb_inv);

   // ie set, exl clear, some unmasked ip bit
   assign int_pending_o = status_w.status.ie & ~status_w.status.exl &
                          (|(status_w.status.im & {cause_w.cause.ip_hw, cause_w.cause.ip_sw}));

   always_comb begin
      except_o       = '0;
      except_o.valid = 1'b1;
      if (int_pending_o) begin
         except_o.code = EXC_INT;
      end else if (itlb_fault) begin
         except_o.code         = EXC_TLBL;
         except_o.is_tlb       = 1'b1;
         except_o.tlb_refill   = except_req_i.itlb_refill;
         except_o.has_badvaddr = 1'b1;
         except_o.bad_from_pc  = 1'b1;
      end else if (dtlb_load || dtlb_store) begin
         except_o.code         = dtlb_load ? EXC_TLBL : EXC_TLBS;
         except_o.is_tlb       = 1'b1;
         except_o.tlb_refill   = except_req_i.dtlb_refill;
         except_o.has_badvaddr = 1'b1;
      end else if (except_req_i.dtlb_mod) begin
         except_o.code         = EXC_MOD;
         except_o.is_tlb       = 1'b1;
         except_o.has_badvaddr = 1'b1;
      end else if (except_req_i.adel || except_req_i.pc_err) begin
         except_o.code         = EXC_ADEL;
         except_o.has_badvaddr = 1'b1;
         except_o.bad_from_pc  = except_req_i.pc_err;  // fetch error beats load error
      end else if (except_req_i.ri) begin
         except_o.code = EXC_RI;
      end else if (except_req_i.syscall) begin
         except_o.code = EXC_SYS;
      end else if (except_req_i.brk) begin
         except_o.code = EXC_BP;
      end else if (except_req_i.ades) begin
         except_o.code         = EXC_ADES;
         except_o.has_badvaddr = 1'b1;
      end else if (except_req_i.ovf) begin
         except_o.code = EXC_OV;
      end else if (except_req_i.trap) begin
         except_o.code = EXC_TR;
      end else begin
         except_o.valid   = 1'b0;
         except_o.is_eret = except_req_i.eret;   // flushes but is no fault
      end
   end

endmodule

// ==== cp0/cp0_regs.sv ====
`include "cp0_config.svh"

module cp0_regs import cp0_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        stall_i,
   input  cp0_wr_t     wr_i,
   input  inst_info_t  inst_i,
   input  except_t     except_i,
   input  logic [5:0]  int_i,
   input  logic [4:0]  raddr_i,
   input  logic [2:0]  rsel_i,
   input  tlb_entry_t  tlb_regs_i,
   output logic [31:0] status_o,
   output logic [31:0] cause_o,
   output logic [31:0] badvaddr_o,
   output logic [31:0] count_o,
   output logic [31:0] random_o,
   output logic [31:0] rdata_o,
   output logic [31:0] handler_pc_o,
   output logic        flush_o
);

   localparam int IDX_W = $clog2(`TLB_LINE_NUM);
   localparam logic [IDX_W-1:0] RANDOM_TOP = IDX_W'(`TLB_LINE_NUM - 1);

   cp0_word_u        status_q;
   cp0_word_u        cause_q;
   cp0_word_u        cause_w;
   cp0_word_u        wdata;
   logic [32:0]      count_q;      // lsb halves the rate
   logic [31:0]      compare_q;
   logic [31:0]      epc_q;
   logic [31:0]      badvaddr_q;
   logic [31:0]      ebase_q;
   logic [IDX_W-1:0] random_q;
   logic [IDX_W-1:0] wired_q;
   logic             timer_int_q;
   logic             wr_en;
   logic             commit;
   logic             eret;
   logic [31:0]      vec_base;
   logic [31:0]      vec_offset;

   assign wdata.word = wr_i.data;
   assign wr_en      = wr_i.we & ~stall_i;
   assign commit     = except_i.valid & ~stall_i;
   assign eret       = except_i.is_eret & ~stall_i;

   assign count_o    = count_q[32:1];
   assign random_o   = {{(32-IDX_W){1'b0}}, random_q};
   assign status_o   = status_q.word;
   assign badvaddr_o = except_i.bad_from_pc ? inst_i.pc : inst_i.data_addr;

   // timers keep running under stall
   always_ff @(posedge clk) begin
      if (rst) begin
         count_q     <= '0;
         compare_q   <= '0;
         timer_int_q <= 1'b0;
         random_q    <= RANDOM_TOP;
         wired_q     <= '0;
      end else begin
         count_q  <= count_q + 33'd1;
         random_q <= (random_q == wired_q) ? RANDOM_TOP : random_q - 1'b1;
         if (compare_q != '0 && count_o == compare_q) begin
            timer_int_q <= 1'b1;
         end
         if (wr_en) begin
            case (wr_i.addr)
               `CP0_REG_COUNT: count_q <= {wr_i.data, 1'b0};
               `CP0_REG_COMPARE: begin
                  compare_q   <= wr_i.data;
                  timer_int_q <= 1'b0;      // ack of timer irq
               end
               `CP0_REG_WIRED: begin
                  wired_q  <= wr_i.data[IDX_W-1:0];
                  random_q <= RANDOM_TOP;
               end
               default: ;
            endcase
         end
      end
   end

   // writes first so a commit overrides them
   always_ff @(posedge clk) begin
      if (rst) begin
         status_q.word <= `CP0_STATUS_RESET;
         cause_q.word  <= '0;
         epc_q         <= '0;
         badvaddr_q    <= '0;
         ebase_q       <= `CP0_EBASE_RESET;
      end else begin
         if (!stall_i) begin
            cause_q.cause.ip_hw <= int_i;
         end
         if (wr_en) begin
            case (wr_i.addr)
               `CP0_REG_STATUS: begin
                  status_q.status.cu  <= wdata.status.cu;
                  status_q.status.bev <= wdata.status.bev;
                  status_q.status.im  <= wdata.status.im;
                  status_q.status.exl <= wdata.status.exl;
                  status_q.status.ie  <= wdata.status.ie;
               end
               `CP0_REG_CAUSE: begin
                  cause_q.cause.iv    <= wdata.cause.iv;
                  cause_q.cause.wp    <= wdata.cause.wp;
                  cause_q.cause.ip_sw <= wdata.cause.ip_sw;
               end
               `CP0_REG_EPC: epc_q <= wr_i.data;
               `CP0_REG_PRID: begin
                  if (wr_i.sel == 3'd1) begin
                     ebase_q[29:0] <= wr_i.data[29:0];
                  end
               end
               default: ;
            endcase
         end
         if (commit) begin
            status_q.status.exl    <= 1'b1;
            cause_q.cause.bd       <= inst_i.in_delay_slot;
            cause_q.cause.exc_code <= except_i.code;
            epc_q <= inst_i.in_delay_slot ? inst_i.pc - 32'd4 : inst_i.pc;
            if (except_i.has_badvaddr) begin
               badvaddr_q <= badvaddr_o;
            end
         end else if (eret) begin
            status_q.status.exl <= 1'b0;
         end
      end
   end

   // timer folds into ip7 and ti
   always_comb begin
      cause_w                = cause_q;
      cause_w.cause.ti       = timer_int_q;
      cause_w.cause.ip_hw[5] = cause_q.cause.ip_hw[5] | timer_int_q;
   end
   assign cause_o = cause_w.word;

   assign vec_base     = status_q.status.bev ? `CP0_BOOT_VECTOR : ebase_q;
   assign vec_offset   = except_i.tlb_refill ? 32'd0 : `CP0_GEN_OFFSET;
   assign handler_pc_o = except_i.is_eret ? epc_q : vec_base + vec_offset;
   assign flush_o      = except_i.valid | eret;

   always_comb begin
      case (raddr_i)
         `CP0_REG_INDEX:    rdata_o = tlb_regs_i.index;
         `CP0_REG_RANDOM:   rdata_o = random_o;
         `CP0_REG_ENTRYLO0: rdata_o = tlb_regs_i.entry_lo0;
         `CP0_REG_ENTRYLO1: rdata_o = tlb_regs_i.entry_lo1;
         `CP0_REG_PAGEMASK: rdata_o = tlb_regs_i.page_mask;
         `CP0_REG_WIRED:    rdata_o = {{(32-IDX_W){1'b0}}, wired_q};
         `CP0_REG_BADVADDR: rdata_o = badvaddr_q;
         `CP0_REG_COUNT:    rdata_o = count_o;
         `CP0_REG_ENTRYHI:  rdata_o = tlb_regs_i.entry_hi;
         `CP0_REG_COMPARE:  rdata_o = compare_q;
         `CP0_REG_STATUS:   rdata_o = status_o;
         `CP0_REG_CAUSE:    rdata_o = cause_o;
         `CP0_REG_EPC:      rdata_o = epc_q;
         `CP0_REG_PRID: begin
            case (rsel_i)
               3'd0:    rdata_o = `CP0_PRID_VALUE;
               3'd1:    rdata_o = ebase_q;
               default: rdata_o = '0;
            endcase
         end
         `CP0_REG_CONFIG:   rdata_o = `CP0_CONFIG_RESET;
         default:           rdata_o = '0;
      endcase
   end

   assert property (@(posedge clk) disable iff (rst)
      random_q >= wired_q && random_q <= RANDOM_TOP)
      else $error("random outside wired..top");

endmodule

// ==== cp0/cp0_tlb_regs.sv ====
`include "cp0_config.svh"

module cp0_tlb_regs import cp0_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        stall_i,
   input  cp0_wr_t     wr_i,
   input  tlb_op_t     tlb_op_i,
   input  tlb_entry_t  tlb_result_i,
   input  except_t     except_i,
   input  logic [31:0] badvaddr_i,
   output tlb_entry_t  tlb_regs_o
);

   localparam int IDX_W = $clog2(`TLB_LINE_NUM);

   logic             probe_miss_q;   // index p bit
   logic [IDX_W-1:0] index_q;
   logic [18:0]      vpn2_q;
   logic [7:0]       asid_q;
   logic [25:0]      entry_lo0_q;    // pfn and c/d/v/g
   logic [25:0]      entry_lo1_q;
   logic [11:0]      mask_q;
   cp0_word_u        wdata;
   cp0_word_u        hi_in;
   logic [11:0]      mask_in;
   logic             wr_en;
   logic             do_tlbp;
   logic             do_tlbr;
   logic             tlb_fault;

   assign wdata.word = wr_i.data;
   assign hi_in.word = tlb_result_i.entry_hi;
   assign mask_in    = tlb_result_i.page_mask[24:13];
   assign wr_en      = wr_i.we & ~stall_i;
   assign do_tlbp    = tlb_op_i.tlbp & ~stall_i;
   assign do_tlbr    = tlb_op_i.tlbr & ~stall_i;
   assign tlb_fault  = except_i.valid & except_i.is_tlb & ~stall_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         probe_miss_q <= 1'b0;
         index_q      <= '0;
         vpn2_q       <= '0;
         asid_q       <= '0;
         entry_lo0_q  <= '0;
         entry_lo1_q  <= '0;
         mask_q       <= '0;
      end else begin
         if (wr_en) begin
            case (wr_i.addr)
               `CP0_REG_INDEX:    index_q <= wr_i.data[IDX_W-1:0];
               `CP0_REG_ENTRYLO0: entry_lo0_q <= wr_i.data[25:0];
               `CP0_REG_ENTRYLO1: entry_lo1_q <= wr_i.data[25:0];
               `CP0_REG_PAGEMASK: mask_q <= wr_i.data[24:13];
               `CP0_REG_ENTRYHI: begin
                  vpn2_q <= wdata.entry_hi.vpn2;
                  asid_q <= wdata.entry_hi.asid;
               end
               default: ;
            endcase
         end
         if (do_tlbp) begin
            probe_miss_q <= tlb_result_i.index[31];
            index_q      <= tlb_result_i.index[IDX_W-1:0];
         end
         if (do_tlbr) begin
            // low pfn/vpn2 bits under the page mask read as zero
            entry_lo0_q <= {tlb_result_i.entry_lo0[25:6] & ~{8'd0, mask_in},
                            tlb_result_i.entry_lo0[5:0]};
            entry_lo1_q <= {tlb_result_i.entry_lo1[25:6] & ~{8'd0, mask_in},
                            tlb_result_i.entry_lo1[5:0]};
            vpn2_q      <= hi_in.entry_hi.vpn2 & ~{7'd0, mask_in};
            asid_q      <= hi_in.entry_hi.asid;
            mask_q      <= mask_in;
         end
         if (tlb_fault) begin
            vpn2_q <= badvaddr_i[31:13];   // refill handler reads it back
         end
      end
   end

   assign tlb_regs_o.index     = {probe_miss_q, {(31-IDX_W){1'b0}}, index_q};
   assign tlb_regs_o.entry_hi  = {vpn2_q, 5'd0, asid_q};
   assign tlb_regs_o.entry_lo0 = {6'd0, entry_lo0_q};
   assign tlb_regs_o.entry_lo1 = {6'd0, entry_lo1_q};
   assign tlb_regs_o.page_mask = {7'd0, mask_q, 13'd0};

   assert property (@(posedge clk) disable iff (rst)
      !(tlb_op_i.tlbp && tlb_op_i.tlbr))
      else $error("tlbp and tlbr in the same cycle");

endmodule

// ==== cp0_top.f ====
+incdir+common
common/cp0_pkg.sv
cp0/cp0_except_arb.sv
cp0/cp0_regs.sv
cp0/cp0_tlb_regs.sv
rtl/cp0_top.sv
test/tb_cp0_top.sv

// ==== rtl/cp0_top.sv ====
module cp0_top import cp0_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  except_req_t except_req_i,
   input  inst_info_t  inst_i,
   input  cp0_wr_t     wr_i,
   input  logic [4:0]  raddr_i,
   input  logic [2:0]  rsel_i,
   input  tlb_op_t     tlb_op_i,
   input  tlb_entry_t  tlb_result_i,
   input  logic [5:0]  int_i,
   input  logic        stall_i,
   output logic [31:0] rdata_o,
   output logic        flush_o,
   output logic [31:0] handler_pc_o,
   output logic        int_pending_o,
   output tlb_entry_t  tlb_regs_o,
   output logic [31:0] count_o,
   output logic [31:0] random_o
);

   logic [31:0] status;
   logic [31:0] cause;
   logic [31:0] badvaddr;   // address of the faulting access
   except_t     except;

   cp0_except_arb i_arb (
      .except_req_i  (except_req_i),
      .status_i      (status),
      .cause_i       (cause),
      .except_o      (except),
      .int_pending_o (int_pending_o)
   );

   cp0_regs i_regs (
      .clk          (clk),
      .rst          (rst),
      .stall_i      (stall_i),
      .wr_i         (wr_i),
      .inst_i       (inst_i),
      .except_i     (except),
      .int_i        (int_i),
      .raddr_i      (raddr_i),
      .rsel_i       (rsel_i),
      .tlb_regs_i   (tlb_regs_o),
      .status_o     (status),
      .cause_o      (cause),
      .badvaddr_o   (badvaddr),
      .count_o      (count_o),
      .random_o     (random_o),
      .rdata_o      (rdata_o),
      .handler_pc_o (handler_pc_o),
      .flush_o      (flush_o)
   );

   cp0_tlb_regs i_tlb_regs (
      .clk          (clk),
      .rst          (rst),
      .stall_i      (stall_i),
      .wr_i         (wr_i),
      .tlb_op_i     (tlb_op_i),
      .tlb_result_i (tlb_result_i),
      .except_i     (except),
      .badvaddr_i   (badvaddr),
      .tlb_regs_o   (tlb_regs_o)
   );

endmodule

// ==== test/tb_cp0_top.sv ====
`include "cp0_config.svh"

module tb_cp0_top import cp0_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES = 8;
   localparam int PHASE_CYCLES = 600;
   localparam int NUM_PHASES   = 4;
   localparam int CYCLE_LIMIT  = NUM_PHASES * PHASE_CYCLES + RESET_CYCLES + 100;

   localparam logic [31:0] STATUS_WMASK = 32'hf040_ff03;   // cu, bev, im, exl, ie
   localparam logic [31:0] CAUSE_WMASK  = 32'h00c0_0300;   // iv, wp, ip1..ip0
   localparam logic [31:0] PM_MASK      = 32'h01ff_e000;
   localparam logic [31:0] HI_MASK      = 32'hffff_e0ff;
   localparam logic [31:0] LO_MASK      = 32'h03ff_ffff;

   logic        clk = 1'b0;
   logic        rst;
   except_req_t except_req;
   inst_info_t  inst;
   cp0_wr_t     wr;
   logic [4:0]  raddr;
   logic [2:0]  rsel;
   tlb_op_t     tlb_op;
   tlb_entry_t  tlb_res;
   logic [5:0]  int_in;
   logic        stall;
   logic [31:0] rdata;
   logic        flush;
   logic [31:0] handler_pc;
   logic        int_pending;
   tlb_entry_t  tlb_regs;
   logic [31:0] count;
   logic [31:0] random_val;

   integer     seed = 32'hfd6d;
   int         cycles = 0;
   int         errors = 0;
   logic [4:0] last_waddr = '0;

   // reference model of the cp0 state
   logic [32:0] m_count;      // lsb is the half-rate prescaler
   logic [31:0] m_compare;
   logic        m_timer;
   logic [3:0]  m_random;
   logic [3:0]  m_wired;
   logic [31:0] m_status;
   logic [31:0] m_cause;      // without the timer bits
   logic [31:0] m_epc;
   logic [31:0] m_badvaddr;
   logic [31:0] m_ebase;
   logic        m_probe;
   logic [3:0]  m_index;
   logic [31:0] m_entry_hi;
   logic [31:0] m_lo0;
   logic [31:0] m_lo1;
   logic [31:0] m_page_mask;

   always #20 clk = ~clk;

   cp0_top i_dut (
      .clk           (clk),
      .rst           (rst),
      .except_req_i  (except_req),
      .inst_i        (inst),
      .wr_i          (wr),
      .raddr_i       (raddr),
      .rsel_i        (rsel),
      .tlb_op_i      (tlb_op),
      .tlb_result_i  (tlb_res),
      .int_i         (int_in),
      .stall_i       (stall),
      .rdata_o       (rdata),
      .flush_o       (flush),
      .handler_pc_o  (handler_pc),
      .int_pending_o (int_pending),
      .tlb_regs_o    (tlb_regs),
      .count_o       (count),
      .random_o      (random_val)
   );

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > CYCLE_LIMIT) begin
         $display("timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
         $display("Simulation finished: FAIL");
         $fatal(1, "run aborted");
      end
   end

   task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
      errors++;
      $display("MISMATCH %s expected %h actual %h (cycle %0d)", name, exp, act, cycles);
      $display("Simulation finished: FAIL");
      $fatal(1, "check failed");
   endtask

   task automatic check_equal(string name, logic [31:0] exp, logic [31:0] act);
      assert (act === exp)
         else report_mismatch(name, exp, act);
   endtask

   function automatic logic [31:0] cause_word();
      logic [31:0] c;
      c     = m_cause;
      c[30] = m_timer;              // ti
      c[15] = m_cause[15] | m_timer; // ip7
      return c;
   endfunction

   function automatic logic int_pend();
      logic [31:0] c;
      c = cause_word();
      return m_status[0] & ~m_status[1] & (|(m_status[15:8] & c[15:8]));
   endfunction

   function automatic except_t pick(exc_code_e code, logic badv, logic from_pc,
                                    logic tlb, logic refill);
      except_t e;
      e              = '0;
      e.valid        = 1'b1;
      e.code         = code;
      e.has_badvaddr = badv;
      e.bad_from_pc  = from_pc;
      e.is_tlb       = tlb;
      e.tlb_refill   = refill;
      return e;
   endfunction

   // lowest priority first so higher causes overwrite
   function automatic except_t arbitrate(except_req_t r, logic pend);
      except_t e;
      logic    dtlb;
      dtlb      = r.dtlb_refill | r.dtlb_inv;
      e         = '0;
      e.is_eret = r.eret;
      if (r.trap) e = pick(EXC_TR, 1'b0, 1'b0, 1'b0, 1'b0);
      if (r.ovf) e = pick(EXC_OV, 1'b0, 1'b0, 1'b0, 1'b0);
      if (r.ades) e = pick(EXC_ADES, 1'b1, 1'b0, 1'b0, 1'b0);
      if (r.brk) e = pick(EXC_BP, 1'b0, 1'b0, 1'b0, 1'b0);
      if (r.syscall) e = pick(EXC_SYS, 1'b0, 1'b0, 1'b0, 1'b0);
      if (r.ri) e = pick(EXC_RI, 1'b0, 1'b0, 1'b0, 1'b0);
      if (r.adel || r.pc_err) e = pick(EXC_ADEL, 1'b1, r.pc_err, 1'b0, 1'b0);
      if (r.dtlb_mod) e = pick(EXC_MOD, 1'b1, 1'b0, 1'b1, 1'b0);
      if (dtlb && r.mem_write) e = pick(EXC_TLBS, 1'b1, 1'b0, 1'b1, r.dtlb_refill);
      if (dtlb && r.mem_read) e = pick(EXC_TLBL, 1'b1, 1'b0, 1'b1, r.dtlb_refill);
      if (r.itlb_refill || r.itlb_inv) e = pick(EXC_TLBL, 1'b1, 1'b1, 1'b1, r.itlb_refill);
      if (pend) e = pick(EXC_INT, 1'b0, 1'b0, 1'b0, 1'b0);
      return e;
   endfunction

   function automatic logic [31:0] model_read(logic [4:0] a, logic [2:0] s);
      case (a)
         `CP0_REG_INDEX:    return {m_probe, 27'd0, m_index};
         `CP0_REG_RANDOM:   return {28'd0, m_random};
         `CP0_REG_ENTRYLO0: return m_lo0;
         `CP0_REG_ENTRYLO1: return m_lo1;
         `CP0_REG_PAGEMASK: return m_page_mask;
         `CP0_REG_WIRED:    return {28'd0, m_wired};
         `CP0_REG_BADVADDR: return m_badvaddr;
         `CP0_REG_COUNT:    return m_count[32:1];
         `CP0_REG_ENTRYHI:  return m_entry_hi;
         `CP0_REG_COMPARE:  return m_compare;
         `CP0_REG_STATUS:   return m_status;
         `CP0_REG_CAUSE:    return cause_word();
         `CP0_REG_EPC:      return m_epc;
         `CP0_REG_PRID:     return (s == 3'd0) ? `CP0_PRID_VALUE : (s == 3'd1) ? m_ebase : 32'd0;
         `CP0_REG_CONFIG:   return `CP0_CONFIG_RESET;
         default:           return 32'd0;
      endcase
   endfunction

   // applies the inputs seen at this edge, called right after posedge
   task automatic update_model();
      except_t     e;
      logic [31:0] bad;
      logic [31:0] pm;
      logic        go;
      if (rst) begin
         m_count     = '0;
         m_compare   = '0;
         m_timer     = 1'b0;
         m_random    = 4'd15;
         m_wired     = '0;
         m_status    = `CP0_STATUS_RESET;
         m_cause     = '0;
         m_epc       = '0;
         m_badvaddr  = '0;
         m_ebase     = `CP0_EBASE_RESET;
         m_probe     = 1'b0;
         m_index     = '0;
         m_entry_hi  = '0;
         m_lo0       = '0;
         m_lo1       = '0;
         m_page_mask = '0;
      end else begin
         go  = ~stall;
         e   = arbitrate(except_req, int_pend());
         bad = e.bad_from_pc ? inst.pc : inst.data_addr;
         if (m_compare != 32'd0 && m_count[32:1] == m_compare) m_timer = 1'b1;
         m_random = (m_random == m_wired) ? 4'd15 : m_random - 4'd1;
         m_count  = m_count + 33'd1;
         if (go) m_cause[15:10] = int_in;
         if (wr.we && go) begin
            case (wr.addr)
               `CP0_REG_COUNT:    m_count = {wr.data, 1'b0};
               `CP0_REG_COMPARE: begin
                  m_compare = wr.data;
                  m_timer   = 1'b0;
               end
               `CP0_REG_WIRED: begin
                  m_wired  = wr.data[3:0];
                  m_random = 4'd15;
               end
               `CP0_REG_STATUS:   m_status = (m_status & ~STATUS_WMASK) | (wr.data & STATUS_WMASK);
               `CP0_REG_CAUSE:    m_cause = (m_cause & ~CAUSE_WMASK) | (wr.data & CAUSE_WMASK);
               `CP0_REG_EPC:      m_epc = wr.data;
               `CP0_REG_PRID:     if (wr.sel == 3'd1) m_ebase[29:0] = wr.data[29:0];
               `CP0_REG_INDEX:    m_index = wr.data[3:0];
               `CP0_REG_ENTRYLO0: m_lo0 = wr.data & LO_MASK;
               `CP0_REG_ENTRYLO1: m_lo1 = wr.data & LO_MASK;
               `CP0_REG_PAGEMASK: m_page_mask = wr.data & PM_MASK;
               `CP0_REG_ENTRYHI:  m_entry_hi = wr.data & HI_MASK;
               default: ;
            endcase
         end
         if (tlb_op.tlbp && go) begin
            m_probe = tlb_res.index[31];
            m_index = tlb_res.index[3:0];
         end
         if (tlb_op.tlbr && go) begin
            pm          = tlb_res.page_mask & PM_MASK;
            m_page_mask = pm;
            m_entry_hi  = tlb_res.entry_hi & HI_MASK & ~pm;
            m_lo0       = tlb_res.entry_lo0 & LO_MASK & ~(pm >> 7);  // mask lines up with pfn
            m_lo1       = tlb_res.entry_lo1 & LO_MASK & ~(pm >> 7);
         end
         if (e.valid && go) begin
            m_status[1]  = 1'b1;
            m_cause[31]  = inst.in_delay_slot;
            m_cause[6:2] = e.code;
            m_epc        = inst.in_delay_slot ? inst.pc - 32'd4 : inst.pc;
            if (e.has_badvaddr) m_badvaddr = bad;
            if (e.is_tlb) m_entry_hi[31:13] = bad[31:13];
         end else if (e.is_eret && go) begin
            m_status[1] = 1'b0;
         end
      end
   endtask

   task automatic check_outputs();
      except_t     e;
      logic [31:0] exp_pc;
      e      = arbitrate(except_req, int_pend());
      exp_pc = m_status[22] ? `CP0_BOOT_VECTOR : m_ebase;
      if (!e.tlb_refill) exp_pc = exp_pc + 32'h180;
      if (e.is_eret) exp_pc = m_epc;   // eret returns to epc
      check_equal("rdata_o", model_read(raddr, rsel), rdata);
      check_equal("flush_o", e.valid | (e.is_eret & ~stall), flush);
      check_equal("int_pending_o", int_pend(), int_pending);
      if (e.valid || e.is_eret) check_equal("handler_pc_o", exp_pc, handler_pc);
      check_equal("count_o", m_count[32:1], count);
      check_equal("random_o", {28'd0, m_random}, random_val);
      check_equal("tlb_regs_o.index", {m_probe, 27'd0, m_index}, tlb_regs.index);
      check_equal("tlb_regs_o.entry_hi", m_entry_hi, tlb_regs.entry_hi);
      check_equal("tlb_regs_o.entry_lo0", m_lo0, tlb_regs.entry_lo0);
      check_equal("tlb_regs_o.entry_lo1", m_lo1, tlb_regs.entry_lo1);
      check_equal("tlb_regs_o.page_mask", m_page_mask, tlb_regs.page_mask);
   endtask

   function automatic logic [4:0] pick_reg(int phase, int k);
      if (phase == 1) begin
         case (k % 4)
            0:       return `CP0_REG_CAUSE;
            1:       return `CP0_REG_EPC;
            2:       return `CP0_REG_STATUS;
            default: return `CP0_REG_BADVADDR;
         endcase
      end else if (phase == 2) begin
         case (k % 4)
            0:       return `CP0_REG_STATUS;
            1:       return `CP0_REG_CAUSE;
            2:       return `CP0_REG_COMPARE;
            default: return `CP0_REG_WIRED;
         endcase
      end else begin
         case (k % 5)
            0:       return `CP0_REG_INDEX;
            1:       return `CP0_REG_ENTRYLO0;
            2:       return `CP0_REG_ENTRYLO1;
            3:       return `CP0_REG_PAGEMASK;
            default: return `CP0_REG_ENTRYHI;
         endcase
      end
   endfunction

   // phase 0 mtc0/mfc0, 1 exceptions/eret/stall, 2 interrupts/timer, 3 tlb
   task automatic drive_random(int phase);
      except_req_t r;
      inst_info_t  in;
      cp0_wr_t     w;
      tlb_op_t     op;
      tlb_entry_t  res;
      logic [5:0]  irq;
      logic        st;
      logic [4:0]  ra;
      logic [2:0]  rs;
      int          k;
      r                = '0;
      op               = '0;
      irq              = '0;
      in.pc            = $random(seed) & 32'hffff_fffc;
      in.data_addr     = $random(seed);
      in.in_delay_slot = 1'($random(seed));
      res    = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
      w.data = $random(seed);
      w.sel  = 3'($random(seed) & 3);
      w.addr = 5'($random(seed));
      w.we   = 1'b0;
      rs     = 3'($random(seed) & 3);
      ra     = 5'($random(seed));
      st     = (($random(seed) & 7) == 0);
      k      = $random(seed) & 32'hff;
      case (phase)
         0: begin
            w.we = 1'($random(seed));
            if (k[2]) ra = last_waddr;   // read back the previous write
         end
         1: begin
            r      = except_req_t'(16'($random(seed) & $random(seed) & $random(seed)));
            st     = (($random(seed) & 3) == 0);
            w.we   = (($random(seed) & 7) == 0);
            w.addr = pick_reg(1, k);
            if (k[2]) ra = pick_reg(1, k >> 4);
         end
         2: begin
            irq    = 6'($random(seed) & $random(seed));
            r.eret = (($random(seed) & 7) == 0);   // leave exl now and then
            w.we   = (($random(seed) & 3) == 0);
            w.addr = pick_reg(2, k);
            if (w.addr == `CP0_REG_COMPARE) w.data = m_count[32:1] + 32'd2 + ((k >> 4) & 7);
            if (k[2]) ra = `CP0_REG_CAUSE;
         end
         default: begin
            r      = except_req_t'(16'($random(seed) & $random(seed)) & 16'h00ff);
            w.we   = (($random(seed) & 3) == 0);
            w.addr = pick_reg(3, k);
            case ($random(seed) & 3)
               0:       op.tlbp = 1'b1;
               1:       op.tlbr = 1'b1;
               default: ;
            endcase
         end
      endcase
      if (w.we) last_waddr = w.addr;
      except_req <= r;
      inst       <= in;
      wr         <= w;
      tlb_op     <= op;
      tlb_res    <= res;
      int_in     <= irq;
      stall      <= st;
      raddr      <= ra;
      rsel       <= rs;
   endtask

   task automatic run_phase(int phase);
      for (int i = 0; i < PHASE_CYCLES; i++) begin
         @(posedge clk);
         update_model();
         drive_random(phase);
         @(negedge clk);
         check_outputs();
      end
   endtask

   initial begin
      rst        <= 1'b1;
      except_req <= '0;
      inst       <= '0;
      wr         <= '0;
      raddr      <= '0;
      rsel       <= '0;
      tlb_op     <= '0;
      tlb_res    <= '0;
      int_in     <= '0;
      stall      <= 1'b0;
      repeat (RESET_CYCLES) begin
         @(posedge clk);
         update_model();
      end
      rst <= 1'b0;
      for (int p = 0; p < NUM_PHASES; p++) begin
         run_phase(p);
      end
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule
